// ==== common/corr_pkg.sv ====
`default_nettype none

package corr_pkg;

  // Array geometry
  localparam int N_ANT     = 4;
  localparam int N_BASE    = 6;  // N_ANT * (N_ANT - 1) / 2
  localparam int ANT_BITS  = 2;
  localparam int BASE_BITS = 3;

  // Output word layout
  localparam int ACCUM     = 32;
  localparam int WORD_BITS = 2 * ACCUM;  // {re, im}

  // Antenna pairs in baseline order
  localparam logic [ANT_BITS-1:0] BASE_A [N_BASE] = '{
    2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2
  };
  localparam logic [ANT_BITS-1:0] BASE_B [N_BASE] = '{
    2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3
  };

  // Sample buffer FSM
  typedef enum logic {
    FILL,
    REPLAY
  } buf_state_e;

endpackage

`default_nettype wire

// ==== common/corr_feed_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Replayed sample pairs for one baseline pass at a time
interface corr_feed_if;

  logic                           valid;
  logic                           first;  // First sample of a pass
  logic                           last;   // Last sample of a pass
  logic [corr_pkg::BASE_BITS-1:0] baseline;
  logic                           a_i;
  logic                           a_q;
  logic                           b_i;
  logic                           b_q;

  modport source (output valid, first, last, baseline, a_i, a_q, b_i, b_q);
  modport sink   (input  valid, first, last, baseline, a_i, a_q, b_i, b_q);

endinterface

`default_nettype wire

// ==== common/vis_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Per-baseline partial visibilities
interface vis_stream_if #(
  parameter int PSUM_W = 6
);

  logic                           valid;
  logic [corr_pkg::BASE_BITS-1:0] baseline;
  logic                           block_first;  // First block of a frame
  logic                           block_last;   // Last block of a frame
  logic signed [PSUM_W-1:0]       re;
  logic signed [PSUM_W-1:0]       im;

  modport source (output valid, baseline, block_first, block_last, re, im);
  modport sink   (input  valid, baseline, block_first, block_last, re, im);

endinterface

`default_nettype wire

// ==== hw/correlator/sample_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
  parameter int COUNT = 8
) (
  input  logic                       vis_clock,
  input  logic                       vis_reset,
  input  logic                       sig_valid_i,
  input  logic [corr_pkg::N_ANT-1:0] sig_idata_i,
  input  logic [corr_pkg::N_ANT-1:0] sig_qdata_i,
  output logic                       start_o,
  output logic                       frame_o,
  corr_feed_if.source                feed
);

  localparam int ADDR_W = (COUNT > 1) ? $clog2(COUNT) : 1;

  logic [corr_pkg::N_ANT-1:0] mem_i [2][COUNT];
  logic [corr_pkg::N_ANT-1:0] mem_q [2][COUNT];

  corr_pkg::buf_state_e           state;
  logic                           wr_bank;
  logic [ADDR_W-1:0]              wr_addr;
  logic                           rd_bank;
  logic [ADDR_W-1:0]              rd_addr;
  logic [corr_pkg::BASE_BITS-1:0] rd_base;
  logic                           block_done;
  logic                           pass_end;
  logic [corr_pkg::N_ANT-1:0]     rd_i;
  logic [corr_pkg::N_ANT-1:0]     rd_q;
  logic [corr_pkg::ANT_BITS-1:0]  ant_a;
  logic [corr_pkg::ANT_BITS-1:0]  ant_b;

  assign block_done = sig_valid_i && (wr_addr == ADDR_W'(COUNT - 1));
  assign pass_end   = (rd_addr == ADDR_W'(COUNT - 1));

  // Sample store writes only the fill bank
  always_ff @(posedge vis_clock) begin
    if (sig_valid_i) begin
      mem_i[wr_bank][wr_addr] <= sig_idata_i;
      mem_q[wr_bank][wr_addr] <= sig_qdata_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      state   <= corr_pkg::FILL;
      wr_bank <= 1'b0;
      wr_addr <= '0;
      rd_bank <= 1'b0;
      rd_addr <= '0;
      rd_base <= '0;
    end else begin
      if (sig_valid_i) begin
        wr_addr <= block_done ? '0 : wr_addr + 1'b1;
      end
      if (state == corr_pkg::REPLAY) begin
        if (pass_end) begin
          rd_addr <= '0;
          rd_base <= rd_base + 1'b1;  // Next baseline
          if (rd_base == corr_pkg::BASE_BITS'(corr_pkg::N_BASE - 1)) begin
            state <= corr_pkg::FILL;
          end
        end else begin
          rd_addr <= rd_addr + 1'b1;
        end
      end
      // A full bank wins over the end of the previous replay
      if (block_done) begin
        wr_bank <= ~wr_bank;
        rd_bank <= wr_bank;
        rd_addr <= '0;
        rd_base <= '0;
        state   <= corr_pkg::REPLAY;
      end
    end
  end

  // Status goes high with the first replay beat
  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      start_o <= 1'b0;
      frame_o <= 1'b0;
    end else begin
      start_o <= block_done && !frame_o;
      if (block_done) begin
        frame_o <= 1'b1;
      end
    end
  end

  assign rd_i  = mem_i[rd_bank][rd_addr];
  assign rd_q  = mem_q[rd_bank][rd_addr];
  assign ant_a = corr_pkg::BASE_A[rd_base];
  assign ant_b = corr_pkg::BASE_B[rd_base];

  assign feed.valid    = (state == corr_pkg::REPLAY);
  assign feed.first    = (rd_addr == '0);
  assign feed.last     = pass_end;
  assign feed.baseline = rd_base;
  assign feed.a_i      = rd_i[ant_a];
  assign feed.a_q      = rd_q[ant_a];
  assign feed.b_i      = rd_i[ant_b];
  assign feed.b_q      = rd_q[ant_b];

endmodule

`default_nettype wire

// ==== hw/correlator/baseline_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module baseline_correlator #(
  parameter int COUNT      = 8,
  parameter int ACC_BLOCKS = 4
) (
  input  logic         vis_clock,
  input  logic         vis_reset,
  corr_feed_if.sink    feed,
  vis_stream_if.source vis
);

  localparam int PSUM_W = $clog2(COUNT) + 3;  // Holds +/-2*COUNT
  localparam int BLK_W  = (ACC_BLOCKS > 1) ? $clog2(ACC_BLOCKS) : 1;

  logic signed [1:0]        p_ii;
  logic signed [1:0]        p_qq;
  logic signed [1:0]        p_qi;
  logic signed [1:0]        p_iq;
  logic signed [PSUM_W-1:0] c_re;
  logic signed [PSUM_W-1:0] c_im;
  logic signed [PSUM_W-1:0] sum_re;
  logic signed [PSUM_W-1:0] sum_im;
  logic signed [PSUM_W-1:0] nxt_re;
  logic signed [PSUM_W-1:0] nxt_im;
  logic [BLK_W-1:0]         blk_cnt;
  logic                     emit;

  // Equal sign bits give a product of +1
  function automatic logic signed [1:0] sign_mul(input logic x, input logic y);
    return (x == y) ? 2'sb01 : 2'sb11;
  endfunction

  assign p_ii = sign_mul(feed.a_i, feed.b_i);
  assign p_qq = sign_mul(feed.a_q, feed.b_q);
  assign p_qi = sign_mul(feed.a_q, feed.b_i);
  assign p_iq = sign_mul(feed.a_i, feed.b_q);

  assign c_re = p_ii + p_qq;
  assign c_im = p_qi - p_iq;

  assign nxt_re = feed.first ? c_re : sum_re + c_re;  // Restart on first
  assign nxt_im = feed.first ? c_im : sum_im + c_im;
  assign emit   = feed.valid && feed.last;

  always_ff @(posedge vis_clock) begin
    if (feed.valid) begin
      sum_re <= nxt_re;
      sum_im <= nxt_im;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      vis.valid <= 1'b0;
      blk_cnt   <= '0;
    end else begin
      vis.valid <= emit;
      // Block ends with the last baseline pass
      if (emit && feed.baseline == corr_pkg::BASE_BITS'(corr_pkg::N_BASE - 1)) begin
        blk_cnt <= (blk_cnt == BLK_W'(ACC_BLOCKS - 1)) ? '0 : blk_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge vis_clock) begin
    if (emit) begin
      vis.re          <= nxt_re;
      vis.im          <= nxt_im;
      vis.baseline    <= feed.baseline;
      vis.block_first <= (blk_cnt == '0);
      vis.block_last  <= (blk_cnt == BLK_W'(ACC_BLOCKS - 1));
    end
  end

endmodule

`default_nettype wire

// ==== hw/correlator/vis_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module vis_accumulator #(
  parameter int COUNT = 8
) (
  input  logic                           vis_clock,
  input  logic                           vis_reset,
  vis_stream_if.sink                     vis,
  output logic                           wr_o,
  output logic [corr_pkg::WORD_BITS-1:0] word_o,
  output logic                           last_o
);

  localparam int PSUM_W = $clog2(COUNT) + 3;
  localparam int EXT_W  = corr_pkg::ACCUM - PSUM_W;

  // One pair of accumulators per baseline
  logic signed [corr_pkg::ACCUM-1:0] acc_re [corr_pkg::N_BASE];
  logic signed [corr_pkg::ACCUM-1:0] acc_im [corr_pkg::N_BASE];

  logic signed [corr_pkg::ACCUM-1:0] ext_re;
  logic signed [corr_pkg::ACCUM-1:0] ext_im;
  logic signed [corr_pkg::ACCUM-1:0] nxt_re;
  logic signed [corr_pkg::ACCUM-1:0] nxt_im;
  logic                              done;

  assign ext_re = {{EXT_W{vis.re[PSUM_W-1]}}, vis.re};
  assign ext_im = {{EXT_W{vis.im[PSUM_W-1]}}, vis.im};

  // Load on the first block of a frame, add otherwise
  assign nxt_re = vis.block_first ? ext_re : acc_re[vis.baseline] + ext_re;
  assign nxt_im = vis.block_first ? ext_im : acc_im[vis.baseline] + ext_im;
  assign done   = vis.valid && vis.block_last;

  always_ff @(posedge vis_clock) begin
    if (vis.valid) begin
      acc_re[vis.baseline] <= nxt_re;
      acc_im[vis.baseline] <= nxt_im;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_o <= 1'b0;
    end else begin
      wr_o <= done;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (done) begin
      word_o <= {nxt_re, nxt_im};  // Real part on top
      last_o <= (vis.baseline == corr_pkg::BASE_BITS'(corr_pkg::N_BASE - 1));
    end
  end

endmodule

`default_nettype wire

// ==== hw/output/vis_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vis_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                           vis_clock,
  input  logic                           vis_reset,
  input  logic                           wr_i,
  input  logic [corr_pkg::WORD_BITS-1:0] word_i,
  input  logic                           last_i,
  input  logic                           ready_i,
  output logic                           valid_o,
  output logic [corr_pkg::WORD_BITS-1:0] word_o,
  output logic                           last_o,
  output logic                           overflow_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [corr_pkg::WORD_BITS-1:0] mem_word [FIFO_DEPTH];
  logic                           mem_last [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  // Wraps for any depth, not just powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign push    = wr_i && !full;  // Dropped when full
  assign pop     = valid_o && ready_i;
  assign valid_o = (count != '0);
  assign word_o  = mem_word[rd_ptr];
  assign last_o  = mem_last[rd_ptr];

  always_ff @(posedge vis_clock) begin
    if (push) begin
      mem_word[wr_ptr] <= word_i;
      mem_last[wr_ptr] <= last_i;
    end
  end

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
      if (wr_i && full) begin
        overflow_o <= 1'b1;  // Sticky until reset
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/output/byte_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
  input  logic                           vis_clock,
  input  logic                           vis_reset,
  input  logic                           valid_i,
  input  logic [corr_pkg::WORD_BITS-1:0] word_i,
  input  logic                           last_i,
  input  logic                           m_tready_i,
  output logic                           ready_o,
  output logic                           m_tvalid_o,
  output logic [7:0]                     m_tdata_o,
  output logic                           m_tlast_o
);

  localparam int N_BYTES = corr_pkg::WORD_BITS / 8;
  localparam int IDX_W   = $clog2(N_BYTES);

  logic                           busy;
  logic [IDX_W-1:0]               byte_idx;
  logic [corr_pkg::WORD_BITS-1:0] shreg;
  logic                           word_last;
  logic                           final_byte;
  logic                           fire;

  assign ready_o    = !busy;  // Takes a word only when idle
  assign fire       = busy && m_tready_i;
  assign final_byte = (byte_idx == IDX_W'(N_BYTES - 1));

  assign m_tvalid_o = busy;
  assign m_tdata_o  = shreg[7:0];  // LSB first
  assign m_tlast_o  = busy && word_last && final_byte;

  always_ff @(posedge vis_clock) begin
    if (vis_reset) begin
      busy     <= 1'b0;
      byte_idx <= '0;
    end else begin
      if (valid_i && ready_o) begin
        busy     <= 1'b1;
        byte_idx <= '0;
      end else if (fire) begin
        byte_idx <= byte_idx + 1'b1;
        if (final_byte) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Shift register holds still until the byte is taken
  always_ff @(posedge vis_clock) begin
    if (valid_i && ready_o) begin
      shreg     <= word_i;
      word_last <= last_i;
    end else if (fire) begin
      shreg <= shreg >> 8;
    end
  end

endmodule

`default_nettype wire

// ==== hw/toy_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module toy_correlator #(
  parameter int COUNT      = 8,  // Samples per block
  parameter int ACC_BLOCKS = 4,  // Blocks per frame
  parameter int FIFO_DEPTH = 8
) (
  input  logic                       vis_clock,
  input  logic                       vis_reset,
  input  logic                       sig_valid_i,
  input  logic [corr_pkg::N_ANT-1:0] sig_idata_i,
  input  logic [corr_pkg::N_ANT-1:0] sig_qdata_i,
  input  logic                       m_tready_i,
  output logic                       vis_start_o,
  output logic                       vis_frame_o,
  output logic                       m_tvalid_o,
  output logic [7:0]                 m_tdata_o,
  output logic                       m_tlast_o,
  output logic                       vis_overflow_o
);

  localparam int PSUM_W = $clog2(COUNT) + 3;

  logic                           acc_wr;
  logic [corr_pkg::WORD_BITS-1:0] acc_word;
  logic                           acc_last;
  logic                           q_valid;
  logic                           q_ready;
  logic [corr_pkg::WORD_BITS-1:0] q_word;
  logic                           q_last;

  corr_feed_if                      feed_if ();
  vis_stream_if #(.PSUM_W(PSUM_W))  vis_if ();

  sample_buffer #(.COUNT(COUNT)) u_buffer (
    .vis_clock   (vis_clock),
    .vis_reset   (vis_reset),
    .sig_valid_i (sig_valid_i),
    .sig_idata_i (sig_idata_i),
    .sig_qdata_i (sig_qdata_i),
    .start_o     (vis_start_o),
    .frame_o     (vis_frame_o),
    .feed        (feed_if.source)
  );

  baseline_correlator #(
    .COUNT      (COUNT),
    .ACC_BLOCKS (ACC_BLOCKS)
  ) u_correlator (
    .vis_clock (vis_clock),
    .vis_reset (vis_reset),
    .feed      (feed_if.sink),
    .vis       (vis_if.source)
  );

  vis_accumulator #(.COUNT(COUNT)) u_accum (
    .vis_clock (vis_clock),
    .vis_reset (vis_reset),
    .vis       (vis_if.sink),
    .wr_o      (acc_wr),
    .word_o    (acc_word),
    .last_o    (acc_last)
  );

  vis_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .wr_i       (acc_wr),
    .word_i     (acc_word),
    .last_i     (acc_last),
    .ready_i    (q_ready),
    .valid_o    (q_valid),
    .word_o     (q_word),
    .last_o     (q_last),
    .overflow_o (vis_overflow_o)
  );

  byte_serializer u_serializer (
    .vis_clock  (vis_clock),
    .vis_reset  (vis_reset),
    .valid_i    (q_valid),
    .word_i     (q_word),
    .last_i     (q_last),
    .m_tready_i (m_tready_i),
    .ready_o    (q_ready),
    .m_tvalid_o (m_tvalid_o),
    .m_tdata_o  (m_tdata_o),
    .m_tlast_o  (m_tlast_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_toy_correlator_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_toy_correlator_asserts (
  input wire logic       vis_clock,
  input wire logic       vis_reset,
  input wire logic       vis_start_o,
  input wire logic       vis_frame_o,
  input wire logic       m_tvalid_o,
  input wire logic       m_tready_i,
  input wire logic [7:0] m_tdata_o,
  input wire logic       m_tlast_o
);

  // Byte and last flag hold while the sink stalls
  hold_while_stalled: assert property (
    @(posedge vis_clock) disable iff (vis_reset)
      (m_tvalid_o && !m_tready_i) |=>
        (m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o))
  ) else $error("Output byte changed while m_tready_i was low");

  start_single_cycle: assert property (
    @(posedge vis_clock) disable iff (vis_reset)
      vis_start_o |=> !vis_start_o
  ) else $error("vis_start_o was high for more than one cycle");

  frame_stays_high: assert property (
    @(posedge vis_clock) disable iff (vis_reset)
      !$fell(vis_frame_o)
  ) else $error("vis_frame_o fell outside reset");

endmodule

bind toy_correlator tb_toy_correlator_asserts u_asserts (
  .vis_clock   (vis_clock),
  .vis_reset   (vis_reset),
  .vis_start_o (vis_start_o),
  .vis_frame_o (vis_frame_o),
  .m_tvalid_o  (m_tvalid_o),
  .m_tready_i  (m_tready_i),
  .m_tdata_o   (m_tdata_o),
  .m_tlast_o   (m_tlast_o)
);

`default_nettype wire

// ==== tests/tb_toy_correlator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_toy_correlator;

  localparam int COUNT      = 8;
  localparam int ACC_BLOCKS = 4;
  localparam int FRAME_SAMP = COUNT * ACC_BLOCKS;
  localparam int FRAME_BYTES = 48;  // 6 baselines, 8 bytes each
  localparam int TIMEOUT    = 4000;

  logic                       vis_clock;
  logic                       vis_reset;
  logic                       sig_valid_i;
  logic [corr_pkg::N_ANT-1:0] sig_idata_i;
  logic [corr_pkg::N_ANT-1:0] sig_qdata_i;
  logic                       m_tready_i;
  logic                       vis_start_o;
  logic                       vis_frame_o;
  logic                       m_tvalid_o;
  logic [7:0]                 m_tdata_o;
  logic                       m_tlast_o;
  logic                       vis_overflow_o;

  logic [31:0]                rng;
  int                         ready_mode;  // 0 always ready, 1 random, 2 held low
  bit                         model_on;
  int                         n_samp;
  int                         total_samp;
  int                         errors;
  int                         timeouts;
  int                         n_bytes;
  int                         n_starts;
  logic [corr_pkg::N_ANT-1:0] frm_i [FRAME_SAMP];
  logic [corr_pkg::N_ANT-1:0] frm_q [FRAME_SAMP];
  logic [8:0]                 exp_q [$];  // {tlast, tdata}
  logic [8:0]                 exp_byte;

  toy_correlator u_dut (
    .vis_clock      (vis_clock),
    .vis_reset      (vis_reset),
    .sig_valid_i    (sig_valid_i),
    .sig_idata_i    (sig_idata_i),
    .sig_qdata_i    (sig_qdata_i),
    .m_tready_i     (m_tready_i),
    .vis_start_o    (vis_start_o),
    .vis_frame_o    (vis_frame_o),
    .m_tvalid_o     (m_tvalid_o),
    .m_tdata_o      (m_tdata_o),
    .m_tlast_o      (m_tlast_o),
    .vis_overflow_o (vis_overflow_o)
  );

  initial begin
    vis_clock = 1'b0;
    forever #2 vis_clock = ~vis_clock;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bit 0 reads as +1, bit 1 as -1
  function automatic int sign_of(input logic b);
    return b ? -1 : 1;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // One clock edge that also drives the ready line for the current mode
  task automatic tick();
    @(posedge vis_clock);
    rng = xorshift32(rng);
    case (ready_mode)
      0: m_tready_i <= 1'b1;
      1: m_tready_i <= ((rng % 32'd10) >= 32'd3);  // About 30 percent low
      default: m_tready_i <= 1'b0;
    endcase
  endtask

  // Frame sums per baseline in (a, b) order with a < b
  task automatic expect_frame();
    int          re;
    int          im;
    int          base;
    logic [63:0] word;
    base = 0;
    for (int a = 0; a < corr_pkg::N_ANT - 1; a++) begin
      for (int b = a + 1; b < corr_pkg::N_ANT; b++) begin
        re = 0;
        im = 0;
        for (int s = 0; s < FRAME_SAMP; s++) begin
          re += sign_of(frm_i[s][a]) * sign_of(frm_i[s][b]);
          re += sign_of(frm_q[s][a]) * sign_of(frm_q[s][b]);
          im += sign_of(frm_q[s][a]) * sign_of(frm_i[s][b]);
          im -= sign_of(frm_i[s][a]) * sign_of(frm_q[s][b]);
        end
        word = {re, im};
        for (int k = 0; k < 8; k++) begin
          exp_q.push_back({(base == 5 && k == 7), word[8*k +: 8]});  // LSB first
        end
        base++;
      end
    end
  endtask

  task automatic send_sample();
    logic [corr_pkg::N_ANT-1:0] si;
    logic [corr_pkg::N_ANT-1:0] sq;
    int                         gap;
    tick();
    rng = xorshift32(rng);
    si  = rng[3:0];
    sq  = rng[7:4];
    gap = 6 + (int'(rng[15:8]) % 7);
    sig_valid_i <= 1'b1;
    sig_idata_i <= si;
    sig_qdata_i <= sq;
    total_samp++;
    if (model_on) begin
      frm_i[n_samp] = si;
      frm_q[n_samp] = sq;
      n_samp++;
      if (n_samp == FRAME_SAMP) begin
        expect_frame();
        n_samp = 0;
      end
    end
    tick();
    sig_valid_i <= 1'b0;
    repeat (gap - 2) tick();
  endtask

  task automatic run_frames(input int n);
    for (int s = 0; s < n * FRAME_SAMP; s++) begin
      send_sample();
      if (total_samp >= COUNT) begin
        check_bit("vis_frame_o", vis_frame_o, 1'b1);
      end
    end
  endtask

  task automatic reset_dut();
    tick();
    vis_reset   <= 1'b1;
    sig_valid_i <= 1'b0;
    repeat (16) tick();
    vis_reset <= 1'b0;
    n_samp     = 0;
    total_samp = 0;
    exp_q.delete();
  endtask

  task automatic check_idle();
    check_bit("vis_start_o", vis_start_o, 1'b0);
    check_bit("vis_frame_o", vis_frame_o, 1'b0);
    check_bit("m_tvalid_o", m_tvalid_o, 1'b0);
    check_bit("m_tlast_o", m_tlast_o, 1'b0);
    check_bit("vis_overflow_o", vis_overflow_o, 1'b0);
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while ((exp_q.size() != 0 || m_tvalid_o) && cyc < TIMEOUT) begin
      tick();
      cyc++;
    end
    assert (cyc < TIMEOUT) else begin
      timeouts++;
      $display("Timed out waiting for the expected bytes, %0d left", exp_q.size());
    end
  endtask

  task automatic wait_overflow();
    int cyc;
    cyc = 0;
    while (!vis_overflow_o && cyc < 400) begin
      tick();
      cyc++;
    end
    assert (cyc < 400) else begin
      timeouts++;
      $display("Timed out waiting for the overflow flag under a stalled output");
    end
  endtask

  // Output byte checker
  always @(posedge vis_clock) begin
    if (!vis_reset && vis_start_o) begin
      n_starts++;
    end
    if (!vis_reset && m_tvalid_o && m_tready_i) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Byte %h appeared while no frame was pending", m_tdata_o);
      end
      if (exp_q.size() > 0) begin
        exp_byte = exp_q.pop_front();
        assert (m_tdata_o === exp_byte[7:0]) else begin
          errors++;
          $display("error m_tdata_o: byte %0d got %h expected %h",
                   n_bytes, m_tdata_o, exp_byte[7:0]);
        end
        assert (m_tlast_o === exp_byte[8]) else begin
          errors++;
          $display("error m_tlast_o: byte %0d got %h expected %h",
                   n_bytes, m_tlast_o, exp_byte[8]);
        end
      end
      n_bytes++;
    end
  end

  initial begin
    vis_reset   = 1'b1;
    sig_valid_i = 1'b0;
    sig_idata_i = '0;
    sig_qdata_i = '0;
    m_tready_i  = 1'b1;
    rng         = 32'd31621;
    ready_mode  = 0;
    model_on    = 1'b1;
    n_samp      = 0;
    total_samp  = 0;
    errors      = 0;
    timeouts    = 0;
    n_bytes     = 0;
    n_starts    = 0;

    reset_dut();
    tick();
    check_idle();

    // Free-running output
    run_frames(3);
    wait_drain();
    assert (n_bytes == 3 * FRAME_BYTES && n_starts == 1) else begin
      errors++;
      $display("Wrong totals after three frames: %0d bytes, %0d start pulses",
               n_bytes, n_starts);
    end

    // Random back-pressure
    ready_mode = 1;
    run_frames(3);
    wait_drain();
    check_bit("vis_overflow_o", vis_overflow_o, 1'b0);
    assert (n_bytes == 6 * FRAME_BYTES) else begin
      errors++;
      $display("Byte count under back-pressure is %0d", n_bytes);
    end

    // Stalled output until the queue overflows
    model_on   = 1'b0;
    ready_mode = 2;
    run_frames(2);
    wait_overflow();
    check_bit("vis_overflow_o", vis_overflow_o, 1'b1);

    ready_mode = 0;
    reset_dut();
    tick();
    check_idle();

    $display("Errors: %0d, timeouts: %0d, bytes checked: %0d", errors, timeouts, n_bytes);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/corr_pkg.sv
common/corr_feed_if.sv
common/vis_stream_if.sv
hw/correlator/sample_buffer.sv
hw/correlator/baseline_correlator.sv
hw/correlator/vis_accumulator.sv
hw/output/vis_fifo.sv
hw/output/byte_serializer.sv
hw/toy_correlator.sv
tests/tb_toy_correlator_asserts.sv
tests/tb_toy_correlator.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_toy_correlator
FILELIST  := sim.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing --assert
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
